//--- logic/soc_pkg.sv
`default_nettype none

package soc_pkg;

    typedef logic [63:0] xlen_t;     // data and address word
    typedef logic [31:0] inst_t;     // instruction word
    typedef logic [4:0]  reg_idx_t;  // register index
    typedef logic [11:0] csr_addr_t; // csr address

    // one request per cycle, enables valid for that cycle only
    typedef struct packed {
        xlen_t address;
        xlen_t write_data;
        logic  read_enable;
        logic  write_enable;
    } bus_req_t;

    typedef enum logic [1:0] {
        run,       // executing ir
        bubble,    // squashing words fetched before a redirect
        load_wait  // load data returning
    } core_state_t;

    // memory map, region picked by address bits above region_bits
    localparam xlen_t ram_base = 64'h0000_0000_1000_0000;
    localparam xlen_t key_base = 64'h0000_0000_2000_0000;
    localparam xlen_t art_base = 64'h0000_0000_2000_0008; // same region as keys
    localparam int region_bits = 4;                       // addr[31:28]

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_opimm  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam inst_t nop_inst  = 32'h0000_0013; // addi x0, x0, 0
    localparam inst_t mret_inst = 32'h3020_0073;

    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mie     = 12'h304;
    localparam csr_addr_t csr_mtvec   = 12'h305;
    localparam csr_addr_t csr_mepc    = 12'h341;
    localparam csr_addr_t csr_mcause  = 12'h342;
    localparam csr_addr_t csr_mip     = 12'h344;

    localparam xlen_t cause_meint = 64'h8000_0000_0000_000b; // interrupt bit + code 11

endpackage

`default_nettype wire

//--- logic/csr_file.sv
`timescale 1ns/100ps
`default_nettype none

module csr_file import soc_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  csr_addr_t csr_addr,
    input  xlen_t     csr_wdata,
    input  logic      csr_write,
    output xlen_t     csr_rdata,
    input  logic      irq,
    input  xlen_t     trap_pc,
    output logic      take_trap,
    output xlen_t     trap_target,
    input  logic      do_mret,
    output xlen_t     return_target
);

    logic  mstatus_mie; // mstatus bit 3
    logic  mie_meie;    // mie bit 11
    xlen_t mtvec, mepc, mcause;

    assign take_trap     = irq && mstatus_mie && mie_meie;
    assign trap_target   = {mtvec[63:2], 2'b00}; // direct mode only
    assign return_target = mepc;

    always_comb begin
        case (csr_addr)
            csr_mstatus: csr_rdata = {60'b0, mstatus_mie, 3'b0};
            csr_mie:     csr_rdata = {52'b0, mie_meie, 11'b0};
            csr_mip:     csr_rdata = {52'b0, irq, 11'b0};  // meip follows the line
            csr_mtvec:   csr_rdata = mtvec;
            csr_mepc:    csr_rdata = mepc;
            csr_mcause:  csr_rdata = mcause;
            default:     csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_mie <= 1'b0;
            mie_meie    <= 1'b0;
            mtvec       <= '0;
            mepc        <= '0;
            mcause      <= '0;
        end else if (take_trap) begin
            mepc        <= trap_pc;
            mcause      <= cause_meint;
            mstatus_mie <= 1'b0; // no nesting
        end else if (do_mret) begin
            mstatus_mie <= 1'b1;
        end else if (csr_write) begin
            case (csr_addr)
                csr_mstatus: mstatus_mie <= csr_wdata[3];
                csr_mie:     mie_meie    <= csr_wdata[11];
                csr_mtvec:   mtvec       <= csr_wdata;
                csr_mepc:    mepc        <= csr_wdata;
                csr_mcause:  mcause      <= csr_wdata;
                default:     ;           // mip and unknown csrs ignore writes
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core import soc_pkg::*; #(
    parameter xlen_t reset_pc = '0
) (
    input  logic     clk,
    input  logic     reset,
    input  inst_t    instruction, // rom answer to last cycle's pc
    output xlen_t    pc,
    output bus_req_t bus_req,
    input  xlen_t    read_data,
    input  logic     irq,
    output logic     irq_ack,
    output logic     heartbeat
);

    inst_t       ir;
    core_state_t state;
    logic        drain;      // first of two squash cycles
    logic        fetch_live; // rom output lines up with pc
    reg_idx_t    ld_rd;      // load destination, ir moves on before data returns
    xlen_t       regs [32];

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rd, rs1, rs2;
    xlen_t      imm_i, imm_s, imm_u;
    xlen_t      rs1_val, rs2_val;
    logic       is_lui, is_addi, is_ld, is_sd, is_csrrw, is_mret;
    logic       run_gate, exec;

    xlen_t csr_rdata, trap_target, return_target;
    logic  take_trap;

    assign opcode = ir[6:0];
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];

    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1]; // x0 reads as zero
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    // anything else falls through as a no-op
    assign is_lui   = opcode == op_lui;
    assign is_addi  = opcode == op_opimm && funct3 == 3'b000;
    assign is_ld    = opcode == op_load && funct3 == 3'b011;
    assign is_sd    = opcode == op_store && funct3 == 3'b011;
    assign is_csrrw = opcode == op_system && funct3 == 3'b001;
    assign is_mret  = ir == mret_inst;

    assign run_gate = state == run;
    assign exec     = run_gate && !take_trap; // trap wins over ir

    csr_file u_csr (
        .clk           (clk),
        .reset         (reset),
        .csr_addr      (ir[31:20]),
        .csr_wdata     (rs1_val),
        .csr_write     (exec && is_csrrw),
        .csr_rdata     (csr_rdata),
        .irq           (irq && run_gate),   // only sampled while running
        .trap_pc       (pc - 64'd8),        // ir address, not yet executed
        .take_trap     (take_trap),
        .trap_target   (trap_target),
        .do_mret       (exec && is_mret),
        .return_target (return_target)
    );

    // requests straight from execute, slaves act at the closing edge
    always_comb begin
        bus_req = '0;
        if (exec && is_ld) begin
            bus_req.address     = rs1_val + imm_i;
            bus_req.read_enable = 1'b1;
        end else if (exec && is_sd) begin
            bus_req.address      = rs1_val + imm_s;
            bus_req.write_data   = rs2_val;
            bus_req.write_enable = 1'b1;
        end
    end

    // fetch register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir         <= nop_inst;
            fetch_live <= 1'b0;
            heartbeat  <= 1'b0;
        end else begin
            heartbeat  <= ~heartbeat;
            fetch_live <= 1'b1;
            if (!fetch_live)
                ir <= nop_inst;        // rom still answers reset pc from reset
            else if (state != load_wait)
                ir <= instruction;     // in load_wait ir already holds the next word
        end
    end

    // execute sequencing and pc steering
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state   <= run;
            drain   <= 1'b0;
            pc      <= reset_pc;
            irq_ack <= 1'b0;
            ld_rd   <= '0;
        end else begin
            pc      <= pc + 64'd4;
            irq_ack <= 1'b0;
            case (state)
                run: begin
                    if (take_trap) begin
                        pc      <= trap_target;
                        irq_ack <= 1'b1;
                        state   <= bubble;
                        drain   <= 1'b1;
                    end else if (is_mret) begin
                        pc    <= return_target;
                        state <= bubble;
                        drain <= 1'b1;
                    end else if (is_ld) begin
                        pc    <= pc;           // one slot lost to the load
                        ld_rd <= rd;
                        state <= load_wait;
                    end
                end
                bubble: begin
                    // two stale words in flight, rom output and ir
                    drain <= 1'b0;
                    if (!drain)
                        state <= run;
                end
                load_wait: state <= run;
                default:   state <= run;
            endcase
        end
    end

    // register file write port
    always_ff @(posedge clk) begin
        if (state == load_wait) begin
            if (ld_rd != '0)
                regs[ld_rd] <= read_data;
        end else if (exec && rd != '0) begin
            if (is_lui)
                regs[rd] <= imm_u;
            else if (is_addi)
                regs[rd] <= rs1_val + imm_i;
            else if (is_csrrw)
                regs[rd] <= csr_rdata; // old csr value
        end
    end

    a_one_enable: assert property (@(posedge clk) disable iff (!reset)
        !(bus_req.read_enable && bus_req.write_enable));

    a_ack_from_run: assert property (@(posedge clk) disable iff (!reset)
        irq_ack |-> $past(state == run && irq));

endmodule

`default_nettype wire

//--- logic/bus_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module bus_decoder import soc_pkg::*; #(
    parameter int ram_words = 256
) (
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t bus_req,
    output xlen_t    read_data,
    output bus_req_t ram_req,
    output bus_req_t io_req,
    input  xlen_t    ram_rdata,
    input  xlen_t    io_rdata
);

    localparam int region_lsb = 32 - region_bits;       // lowest region select bit
    localparam int ram_span   = $clog2(ram_words) + 3;  // byte address bits in ram

    logic ram_sel, io_sel;
    logic ram_read_q, io_read_q; // where last cycle's read went

    // upper word must be zero too, plus nothing past the end of ram
    assign ram_sel = bus_req.address[63:region_lsb] == ram_base[63:region_lsb]
                     && bus_req.address[region_lsb-1:ram_span] == '0;
    assign io_sel  = bus_req.address[63:region_lsb] == key_base[63:region_lsb];

    always_comb begin
        ram_req              = bus_req;
        ram_req.read_enable  = bus_req.read_enable && ram_sel;
        ram_req.write_enable = bus_req.write_enable && ram_sel;
        io_req               = bus_req;
        io_req.read_enable   = bus_req.read_enable && io_sel;
        io_req.write_enable  = bus_req.write_enable && io_sel;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ram_read_q <= 1'b0;
            io_read_q  <= 1'b0;
        end else begin
            ram_read_q <= ram_req.read_enable;
            io_read_q  <= io_req.read_enable;
        end
    end

    // unmapped reads return zero
    assign read_data = ram_read_q ? ram_rdata : io_read_q ? io_rdata : '0;

    a_one_region: assert property (@(posedge clk) disable iff (!reset)
        $onehot0({ram_req.read_enable, ram_req.write_enable,
                  io_req.read_enable, io_req.write_enable}));

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram import soc_pkg::*; #(
    parameter int ram_words = 256
) (
    input  logic     clk,
    input  bus_req_t req,
    output xlen_t    rdata
);

    localparam int idx_bits = $clog2(ram_words);

    xlen_t                mem [ram_words];
    logic [idx_bits-1:0]  idx;

    assign idx = req.address[idx_bits+2:3]; // doubleword index, byte offset dropped

    always_ff @(posedge clk) begin
        if (req.write_enable)
            mem[idx] <= req.write_data;
        if (req.read_enable)
            rdata <= mem[idx];    // valid the cycle after the request
    end

endmodule

`default_nettype wire

//--- logic/io_regs.sv
`timescale 1ns/100ps
`default_nettype none

module io_regs import soc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  bus_req_t   req,
    output xlen_t      rdata,
    input  logic [7:0] key_data,
    output logic [7:0] art_data,
    output logic       art_valid
);

    logic [7:0] key_q; // sampled key byte
    logic       key_hit, art_hit;

    assign key_hit = req.address == key_base;
    assign art_hit = req.address == art_base;

    always_ff @(posedge clk) begin
        key_q <= key_data;
        rdata <= (req.read_enable && key_hit) ? {56'b0, key_q} : '0;
        if (req.write_enable && art_hit)
            art_data <= req.write_data[7:0]; // low byte only, held till next store
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            art_valid <= 1'b0;
        else
            art_valid <= req.write_enable && art_hit; // one cycle per store
    end

endmodule

`default_nettype wire

//--- logic/soc_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_top import soc_pkg::*; #(
    parameter xlen_t reset_pc  = '0,
    parameter int    ram_words = 256
) (
    input  logic       clk,
    input  logic       reset,
    input  inst_t      instruction,
    output xlen_t      pc,
    input  logic       irq,
    output logic       irq_ack,
    input  logic [7:0] key_data,
    output logic [7:0] art_data,
    output logic       art_valid,
    output logic       heartbeat
);

    bus_req_t bus_req, ram_req, io_req;
    xlen_t    read_data, ram_rdata, io_rdata;

    rv_core #(.reset_pc(reset_pc)) u_core (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .bus_req     (bus_req),
        .read_data   (read_data),
        .irq         (irq),
        .irq_ack     (irq_ack),
        .heartbeat   (heartbeat)
    );

    bus_decoder #(.ram_words(ram_words)) u_dec (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .read_data (read_data),
        .ram_req   (ram_req),
        .io_req    (io_req),
        .ram_rdata (ram_rdata),
        .io_rdata  (io_rdata)
    );

    data_ram #(.ram_words(ram_words)) u_ram (
        .clk   (clk),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

    io_regs u_io (
        .clk       (clk),
        .reset     (reset),
        .req       (io_req),
        .rdata     (io_rdata),
        .key_data  (key_data),
        .art_data  (art_data),
        .art_valid (art_valid)
    );

endmodule

`default_nettype wire

//--- bench/tb_soc.sv
`timescale 1ns/100ps
`default_nettype none

module tb_soc import soc_pkg::*; ();

    localparam xlen_t boot_pc    = 64'h0000_0000_0000_0200; // handler address in the data file assumes this
    localparam int    rom_words  = 32;   // program section, @00 in the data file
    localparam int    data_base  = 32;   // @20 key byte, irq events, characters
    localparam int    irq_events = 2;
    localparam int    run_limit  = 300;  // cycles

    logic       clk;
    logic       reset;
    inst_t      instruction;
    xlen_t      pc;
    logic       irq, irq_ack, art_valid, heartbeat;
    logic [7:0] key_data, art_data;

    logic [31:0] input_mem [64]; // raw image of the data file
    logic [7:0]  expect_q [$];   // characters still owed by the program
    int          mismatch_count, other_count;
    int          cycle;          // edges since reset release
    int          window;         // irq event in progress or next
    int          window_acks;
    logic        window_open;
    logic        last_beat;      // heartbeat seen on the previous edge

    soc_top #(.reset_pc(boot_pc), .ram_words(256)) uut (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .irq         (irq),
        .irq_ack     (irq_ack),
        .key_data    (key_data),
        .art_data    (art_data),
        .art_valid   (art_valid),
        .heartbeat   (heartbeat)
    );

    always #10 clk = ~clk;

    // synchronous rom, unknown or out of range words read as a no-op
    function automatic inst_t rom_word(xlen_t addr);
        xlen_t idx;
        idx = (addr - boot_pc) >> 2;
        if (addr < boot_pc || idx >= rom_words || addr[1:0] != 2'b00)
            return nop_inst;
        if ($isunknown(input_mem[idx]))
            return nop_inst; // past the last program word
        return input_mem[idx];
    endfunction

    always @(posedge clk) begin : drive_and_check
        logic [7:0] head;
        xlen_t      exp_pc;
        instruction <= rom_word(pc);                // answers this cycle's pc
        key_data    <= input_mem[data_base][7:0];
        if (reset) begin
            exp_pc = boot_pc + 4 * cycle;           // straight-line fetch at start
            if (cycle == 0 && (art_valid || irq_ack)) begin
                other_count++;
                $display("art_valid or irq_ack high right after reset at %0t", $time);
            end
            if (cycle < 4 && pc !== exp_pc) begin
                mismatch_count++;
                $display("mismatch at %0t: pc %h, expected %h", $time, pc, exp_pc);
            end
            if (cycle > 0 && heartbeat === last_beat) begin
                mismatch_count++;
                $display("mismatch at %0t: heartbeat stuck at %b", $time, heartbeat);
            end
            last_beat = heartbeat;
            if (art_valid) begin
                if (expect_q.size() == 0) begin
                    other_count++;
                    $display("extra character %h at %0t", art_data, $time);
                end else begin
                    head = expect_q.pop_front();
                    if (art_data !== head) begin
                        mismatch_count++;
                        $display("mismatch at %0t: art_data %h, expected %h",
                                 $time, art_data, head);
                    end
                end
            end
            if (irq_ack) begin
                if (window_open) begin
                    window_acks++;
                end else begin
                    other_count++;
                    $display("irq_ack while irq was low at %0t", $time);
                end
            end
            // irq rises on its cycle, falls with the next character
            if (window_open && art_valid) begin
                irq         <= 1'b0;
                window_open = 1'b0;
                if (window_acks != input_mem[data_base + 2 + 2 * window]) begin
                    mismatch_count++;
                    $display("mismatch at %0t: irq event %0d gave %0d acks, expected %0d",
                             $time, window, window_acks, input_mem[data_base + 2 + 2 * window]);
                end
                window++;
            end else if (!window_open && window < irq_events
                         && cycle == input_mem[data_base + 1 + 2 * window]) begin
                irq         <= 1'b1;
                window_open = 1'b1;
                window_acks = 0;
            end
            cycle++;
        end
    end

    initial begin : run_test
        int waited;
        clk            = 1'b0;
        reset          = 1'b0;
        instruction    = nop_inst;
        irq            = 1'b0;
        key_data       = '0;
        mismatch_count = 0;
        other_count    = 0;
        cycle          = 0;
        window         = 0;
        window_acks    = 0;
        window_open    = 1'b0;
        last_beat      = 1'b0;
        $readmemh("bench/soc_input.txt", input_mem);
        for (int i = 0; i < input_mem[data_base + 1 + 2 * irq_events]; i++)
            expect_q.push_back(input_mem[data_base + 2 + 2 * irq_events + i][7:0]);
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        waited = 0;
        while (expect_q.size() > 0 && waited < run_limit) begin
            @(negedge clk);                         // queue settled by now
            waited++;
        end
        if (expect_q.size() > 0) begin
            other_count++;
            $display("timeout: %0d expected characters never appeared", expect_q.size());
        end
        if (window != irq_events) begin
            other_count++;
            $display("only %0d of %0d irq events finished", window, irq_events);
        end
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/soc_input.txt
// @00 program words from pc 0x200, one per line; @20 key byte, then per irq event its
// raise cycle and expected ack count, then the character count and the characters in order
@00
200000b7 // lui   x1, 0x20000       io base
00001137 // lui   x2, 0x1
04810113 // addi  x2, x2, 0x48      x2 = 0x1048
0020b423 // sd    x2, 8(x1)         'H'
100001b7 // lui   x3, 0x10000       ram base
05200213 // addi  x4, x0, 0x52
0041b823 // sd    x4, 16(x3)
0101b283 // ld    x5, 16(x3)
0050b423 // sd    x5, 8(x1)         'R' back from ram
0000b303 // ld    x6, 0(x1)         key register
0060b423 // sd    x6, 8(x1)
24c00393 // addi  x7, x0, 0x24c     handler address
30539073 // csrrw x0, mtvec, x7
80000413 // addi  x8, x0, -2048     bit 11 set
30441073 // csrrw x0, mie, x8
00800493 // addi  x9, x0, 8
30049073 // csrrw x0, mstatus, x9   interrupts on
05a00593 // addi  x11, x0, 0x5a
00b0b423 // sd    x11, 8(x1)        'Z'
02100513 // addi  x10, x0, 0x21     handler at 0x24c
00a0b423 // sd    x10, 8(x1)        '!'
30200073 // mret
@20
4b                // key byte 'K'
02 0              // irq in early code with interrupts off, no ack
12 1              // irq after enable, one ack
5 48 52 4b 21 5a  // H R K ! Z

//--- compile.f
logic/soc_pkg.sv
logic/csr_file.sv
logic/rv_core.sv
logic/bus_decoder.sv
logic/data_ram.sv
logic/io_regs.sv
logic/soc_top.sv
bench/tb_soc.sv
